// File: dv/main_stim.txt
// kind addr data rom_dly ram_dly blank_dly ipl_n, all hex; kind 0 read, 1 write, 2 event
// event data bits: 0 lvbl fall, 1 sec2 rise, 2 nexirq_n low, 3 nexirq_n high
0 01234 1234 0 0 0 7
0 2abcd 2bcd 5 0 0 7
0 30010 9a4a 0 0 0 7
0 37ffe e5a4 0 4 0 7
0 3a100 a2c3 0 0 0 7
0 3b000 ffff 0 0 0 7
1 00100 beef 0 0 0 7
0 3c000 0000 0 0 0 7
0 3c001 0000 0 0 0 7
0 3c002 0000 0 0 0 7
0 38020 1a7a 0 1 3 7
0 39fff 05a5 0 0 6 7
1 3d000 12a7 0 0 0 7
1 3d002 00f5 0 0 0 7
2 00000 0001 0 0 0 1
2 00000 0002 0 0 0 1
2 00000 0004 0 0 0 1
1 3d001 0000 0 0 0 2
1 3d003 0000 0 0 0 3
2 00000 0008 0 0 0 7
2 00000 0002 0 0 0 2
1 3d003 0000 0 0 0 7
2 00000 0004 0 0 0 3
2 00000 0008 0 0 0 7
2 00000 0003 0 0 0 1
1 3d001 0000 0 0 0 2
1 3d003 0000 0 0 0 7

// File: sources.f
rtl/main_pkg.sv
rtl/bus_sel_if.sv
rtl/addr_decoder.sv
rtl/cab_inputs.sv
rtl/read_mux.sv
rtl/dtack_gen.sv
rtl/sys_ctrl.sv
rtl/main_bus.sv
dv/clk_gen.sv
dv/main_bus_assert.sv
dv/main_bus_tb.sv

// File: Bender.yml
package:
  name: main_bus

sources:
  - files:
      - rtl/main_pkg.sv
      - rtl/bus_sel_if.sv
      - rtl/addr_decoder.sv
      - rtl/cab_inputs.sv
      - rtl/read_mux.sv
      - rtl/dtack_gen.sv
      - rtl/sys_ctrl.sv
      - rtl/main_bus.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/main_bus_assert.sv
      - dv/main_bus_tb.sv

// File: dv/main_bus_tb.sv
// testbench for the main bus glue, cpu model driven from the stim file, checks and watchdog
module main_bus_tb import main_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int disp_delay = 2;
    localparam int stim_lines = 27;
    localparam int fields     = 7;   // kind addr data rom_dly ram_dly blank_dly ipl_n

    logic       clk, rst, as_n, rnw, uds_n, lds_n, dtack_n;
    waddr_t     addr;
    word_t      cpu_dout, cpu_din, rom_data, ram_data, pal_dout;
    ipl_t       ipl_n;
    logic       lvbl, lhbl, nexirq_n, sec2, service, snreq;
    logic       rom_cs, rom_ok, ram_cs, ram_ok, pal_cs;
    logic [8:0] joystick1, joystick2;
    logic [1:0] start_button, coin_input;
    logic [7:0] dipsw_a, dipsw_b, snd_latch;
    logic [2:0] prisel;

    logic [31:0] stim [0:stim_lines*fields-1];
    logic [31:0] lfsr = 32'hb95a67e5;
    int          pulses;             // snreq pulses seen in the last bus cycle
    int          wd_limit = 0;
    word_t       rd_word;
    logic [2:0]  cs_seen;            // rom, ram, pal selects at the acknowledge

    clk_gen #(.period(20)) i_clk_gen (.clk(clk), .rst(rst));

    main_bus #(.disp_delay(disp_delay)) i_main_bus (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_fail(input string what);
        $display("[FAIL] %0d ns %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            report_fail($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_ipl(input ipl_t got, input ipl_t exp, input string what);
        if (got !== exp)
            report_fail($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            report_fail($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // memory model contents, every address bit counts
    function automatic word_t mem_word(input waddr_t a, input word_t salt);
        return a[15:0] ^ {a[17:16], 14'd0} ^ salt;
    endfunction

    // directions come out in reverse order on the cabinet word
    function automatic logic [8:0] dir_swap(input logic [8:0] j);
        logic [8:0] r;
        r = j;
        for (int i = 0; i < 4; i++)
            r[i] = j[3 - i];
        return r;
    endfunction

    // rom, ram and palette selects from the memory map, rom is read only
    function automatic logic [2:0] expected_cs(input logic wr, input waddr_t a);
        logic [2:0] cs;
        cs = 3'b000;
        if (!wr && a < rom_base + rom_size)
            cs = 3'b100;
        else if (a >= ram_base && a < disp_base + disp_size)
            cs = 3'b010;   // system and display ram share the select
        else if (a >= pal_base && a < pal_base + pal_size)
            cs = 3'b001;
        return cs;
    endfunction

    task automatic apply_event(input logic [3:0] ev);
        @(posedge clk);
        if (ev[0]) lvbl <= 1'b0;
        if (ev[1]) sec2 <= 1'b1;
        if (ev[2]) nexirq_n <= 1'b0;
        if (ev[3]) nexirq_n <= 1'b1;
        @(posedge clk);
        lvbl <= 1'b1;
        sec2 <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_cycle(input logic wr, input waddr_t a, input word_t d,
                             input int rom_dly, input int ram_dly, input int blank_dly);
        int          n;
        int          blank_at;
        logic        done;
        logic [31:0] bits;
        n        = 0;
        blank_at = -1;
        done     = 1'b0;
        pulses   = 0;
        take_bits(23, bits);
        @(posedge clk);
        joystick1    <= bits[8:0];
        joystick2    <= bits[17:9];
        start_button <= bits[19:18];
        coin_input   <= bits[21:20];
        service      <= bits[22];
        addr         <= a;
        rnw          <= ~wr;
        cpu_dout     <= d;
        uds_n        <= 1'b0;
        lds_n        <= 1'b0;
        as_n         <= 1'b0;
        rom_data     <= mem_word(a, 16'h0000);
        ram_data     <= mem_word(a, 16'h5a5a);
        pal_dout     <= mem_word(a, 16'hc3c3);
        rom_ok       <= (rom_dly == 0);
        ram_ok       <= (ram_dly == 0);
        while (!done) begin
            @(posedge clk);
            n++;
            if (snreq) pulses++;
            if (!dtack_n) begin
                done = 1'b1;
            end else begin
                if (n == rom_dly) rom_ok <= 1'b1;
                if (n == ram_dly) ram_ok <= 1'b1;
                if (n == blank_dly) begin
                    lhbl     <= 1'b0;   // horizontal blank starts
                    blank_at = n;
                end
            end
        end
        if (blank_dly != 0 && blank_at < 0)
            stop_run($sformatf("display access at %h acknowledged before the blank", a));
        if (blank_dly != 0 && n - blank_at - 2 < disp_delay)
            stop_run($sformatf("display dtack came %0d cycles after the blank, too early",
                               n - blank_at - 2));
        rd_word = cpu_din;
        cs_seen = {rom_cs, ram_cs, pal_cs};
        as_n   <= 1'b1;
        uds_n  <= 1'b1;
        lds_n  <= 1'b1;
        rnw    <= 1'b1;
        rom_ok <= 1'b0;
        ram_ok <= 1'b0;
        lhbl   <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            if (snreq) pulses++;
        end
        if (dtack_n !== 1'b1)
            stop_run("dtack_n stayed low after as_n rose");
    endtask

    initial begin
        int         kind, rom_dly, ram_dly, blank_dly, max_dly, fails;
        waddr_t     a;
        word_t      d, exp;
        ipl_t       ipl_exp;
        logic [7:0] exp_snd;
        logic [2:0] exp_prisel;
        logic [8:0] s1, s2;
        as_n = 1'b1;
        rnw = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        addr = '0;
        cpu_dout = '0;
        lvbl = 1'b1;
        lhbl = 1'b1;
        nexirq_n = 1'b1;
        sec2 = 1'b0;
        rom_data = '0;
        ram_data = '0;
        pal_dout = '0;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        joystick1 = '0;
        joystick2 = '0;
        start_button = '0;
        coin_input = '0;
        service = 1'b0;
        dipsw_a = 8'h5a;
        dipsw_b = 8'hc3;
        exp_snd = 8'h00;
        exp_prisel = 3'd0;
        $readmemh("dv/main_stim.txt", stim);
        if (^stim[stim_lines*fields-1] === 1'bx)
            stop_run("stimulus file dv/main_stim.txt is missing or too short");
        max_dly = 0;
        for (int n = 0; n < stim_lines; n++)
            for (int f = 3; f < 6; f++)
                if (int'(stim[n*fields+f]) > max_dly) max_dly = int'(stim[n*fields+f]);
        wd_limit = stim_lines * (max_dly + disp_delay + 16) + 64;

        @(negedge rst);
        @(posedge clk);
        check_byte({7'd0, dtack_n}, 8'd1, "dtack_n after reset");
        check_byte({5'd0, rom_cs, ram_cs, pal_cs}, 8'd0, "chip selects after reset");
        check_byte({7'd0, snreq}, 8'd0, "snreq after reset");
        check_ipl(ipl_n, 3'b111, "ipl_n after reset");
        check_byte(snd_latch, 8'h00, "sound latch after reset");
        check_byte({5'd0, prisel}, 8'h00, "priority select after reset");

        for (int n = 0; n < stim_lines; n++) begin
            kind      = int'(stim[n*fields]);
            a         = stim[n*fields+1][17:0];
            d         = stim[n*fields+2][15:0];
            rom_dly   = int'(stim[n*fields+3]);
            ram_dly   = int'(stim[n*fields+4]);
            blank_dly = int'(stim[n*fields+5]);
            ipl_exp   = stim[n*fields+6][2:0];
            if (kind == 2) begin
                apply_event(d[3:0]);
            end else begin
                run_cycle(kind == 1, a, d, rom_dly, ram_dly, blank_dly);
                check_byte({5'd0, cs_seen}, {5'd0, expected_cs(kind == 1, a)},
                           $sformatf("chip selects in the cycle at %h", a));
                check_byte({5'd0, rom_cs, ram_cs, pal_cs}, 8'd0,
                           $sformatf("chip selects after the cycle at %h", a));
                if (kind == 1 && a == wr_snd_addr) exp_snd = d[7:0];
                if (kind == 1 && a == wr_prisel_addr) exp_prisel = d[2:0];
                if (pulses != ((kind == 1 && a == wr_snd_addr) ? 1 : 0))
                    report_fail($sformatf("snreq pulsed %0d times in the cycle at %h", pulses, a));
                if (kind == 0) begin
                    s1 = dir_swap(joystick1);
                    s2 = dir_swap(joystick2);
                    case (a)
                        cab_joy_addr: exp = {s2[7:0], s1[7:0]};
                        cab_sys_addr: exp = {8'hff, ~lvbl, service, coin_input, start_button,
                                             s2[8], s1[8]};
                        cab_dip_addr: exp = {dipsw_b, dipsw_a};
                        default:      exp = d;
                    endcase
                    check_word(rd_word, exp, $sformatf("read data at %h", a));
                end
            end
            check_ipl(ipl_n, ipl_exp, $sformatf("ipl_n after line %0d", n));
            check_byte(snd_latch, exp_snd, "sound latch");
            check_byte({5'd0, prisel}, {5'd0, exp_prisel}, "priority select");
        end

        fails = i_main_bus.i_dtack_gen.i_dtack_assert.fail_count
              + i_main_bus.i_sys_ctrl.i_ctrl_assert.fail_count;
        if (fails == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d bound assertion failures", fails);
            $display("Test failed");
            $fatal(1);
        end
    end

    // watchdog, sized from the stim file
    initial begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge clk);
        stop_run($sformatf("watchdog expired after %0d cycles with a bus cycle still open",
                           wd_limit));
    end

endmodule

// File: dv/main_bus_assert.sv
// bound checks on the acknowledge stage and the sound request pulse
module main_bus_assert import main_pkg::*; #(
    parameter int disp_delay = 2
) (
    input logic         clk,
    input logic         rst,
    input logic         sel_valid,
    input dev_e         dev,
    input logic         lvbl,
    input logic         lhbl,
    input logic         dtack_n,
    input dtack_state_e state,
    input logic         snreq
);
    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;   // read by the testbench at the end
    logic blank_now;
    logic blank_q;          // blank level one cycle back
    logic blank_seen;       // a blank started inside the open bus cycle

    assign blank_now = !lvbl || !lhbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_q    <= 1'b1;
            blank_seen <= 1'b0;
        end else begin
            blank_q    <= blank_now;
            blank_seen <= sel_valid && (blank_seen || (blank_now && !blank_q));
        end
    end

    // edge 3 at the earliest, and never outside a cycle
    dtack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        !dtack_n |-> sel_valid && $past(sel_valid) && $past(sel_valid, 2))
        else begin
            fail_count++;
            $error("dtack_n low outside a bus cycle or before its third edge");
        end

    snreq_single: assert property (@(posedge clk) disable iff (rst) snreq |=> !snreq)
        else begin
            fail_count++;
            $error("snreq high for two cycles");
        end

    // display ack no sooner than disp_delay cycles after the blank start
    disp_ack_late: assert property (@(posedge clk) disable iff (rst)
        ($rose(state == dt_ack) && dev == dev_disp) |-> $past(blank_seen, disp_delay))
        else begin
            fail_count++;
            $error("display acknowledge before the blank delay ran out");
        end

endmodule

bind dtack_gen main_bus_assert #(.disp_delay(disp_delay)) i_dtack_assert (
    .clk       (clk),
    .rst       (rst),
    .sel_valid (sel.sel_valid),
    .dev       (sel.dev),
    .lvbl      (lvbl),
    .lhbl      (lhbl),
    .dtack_n   (dtack_n),
    .state     (state),
    .snreq     (1'b0)
);

bind sys_ctrl main_bus_assert i_ctrl_assert (
    .clk       (clk),
    .rst       (rst),
    .sel_valid (1'b1),
    .dev       (dev_none),
    .lvbl      (1'b1),
    .lhbl      (1'b1),
    .dtack_n   (1'b1),
    .state     (dt_idle),
    .snreq     (snreq)
);

// File: dv/clk_gen.sv
// testbench clock and power-on reset
module clk_gen #(
    parameter int period = 20
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        #(2 * period) rst = 1'b0;   // two rising edges in reset, released on a falling edge
    end

    always #(period / 2) clk = ~clk;

endmodule

// File: rtl/main_bus.sv
// main cpu bus glue top level, decode, data, acknowledge and control stages
module main_bus import main_pkg::*; #(
    parameter int disp_delay = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       as_n,
    input  logic       rnw,
    input  logic       uds_n,
    input  logic       lds_n,
    input  waddr_t     addr,
    input  word_t      cpu_dout,
    output word_t      cpu_din,
    output logic       dtack_n,
    output ipl_t       ipl_n,
    input  logic       lvbl,
    input  logic       lhbl,
    input  logic       nexirq_n,
    input  logic       sec2,
    output logic       rom_cs,
    input  word_t      rom_data,
    input  logic       rom_ok,
    output logic       ram_cs,
    input  word_t      ram_data,
    input  logic       ram_ok,
    output logic       pal_cs,
    input  word_t      pal_dout,
    input  logic [8:0] joystick1,
    input  logic [8:0] joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b,
    output logic       snreq,
    output logic [7:0] snd_latch,
    output logic [2:0] prisel
);

    word_t joy_word, sys_word, dip_word;

    bus_sel_if i_sel ();

    addr_decoder i_addr_decoder (
        .clk      (clk),
        .rst      (rst),
        .as_n     (as_n),
        .rnw      (rnw),
        .uds_n    (uds_n),
        .lds_n    (lds_n),
        .addr     (addr),
        .cpu_dout (cpu_dout),
        .sel      (i_sel.src),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .pal_cs   (pal_cs)
    );

    cab_inputs i_cab_inputs (
        .clk          (clk),
        .rst          (rst),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .lvbl         (lvbl),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .joy_word     (joy_word),
        .sys_word     (sys_word),
        .dip_word     (dip_word)
    );

    read_mux i_read_mux (
        .clk      (clk),
        .rst      (rst),
        .sel      (i_sel.data),
        .rom_data (rom_data),
        .ram_data (ram_data),
        .pal_dout (pal_dout),
        .joy_word (joy_word),
        .sys_word (sys_word),
        .dip_word (dip_word),
        .cpu_din  (cpu_din)
    );

    dtack_gen #(.disp_delay(disp_delay)) i_dtack_gen (
        .clk     (clk),
        .rst     (rst),
        .sel     (i_sel.ack),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .lvbl    (lvbl),
        .lhbl    (lhbl),
        .dtack_n (dtack_n)
    );

    sys_ctrl i_sys_ctrl (
        .clk       (clk),
        .rst       (rst),
        .sel       (i_sel.ctrl),
        .lvbl      (lvbl),
        .sec2      (sec2),
        .nexirq_n  (nexirq_n),
        .snreq     (snreq),
        .snd_latch (snd_latch),
        .prisel    (prisel),
        .ipl_n     (ipl_n)
    );

endmodule

// File: rtl/sys_ctrl.sv
// write registers, sound latch, priority select and interrupt level encoder
module sys_ctrl import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    bus_sel_if.ctrl    sel,
    input  logic       lvbl,
    input  logic       sec2,
    input  logic       nexirq_n,
    output logic       snreq,
    output logic [7:0] snd_latch,
    output logic [2:0] prisel,
    output ipl_t       ipl_n
);

    logic wr_start, lvbl_l, sec2_l, vint, secirq;

    assign wr_start = sel.sel_start & ~sel.rnw;   // once per write cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snreq     <= 1'b0;
            snd_latch <= 8'd0;
            prisel    <= 3'd0;
            vint      <= 1'b0;
            secirq    <= 1'b0;
            lvbl_l    <= 1'b0;
            sec2_l    <= 1'b1;
        end else begin
            snreq <= wr_start && (sel.dev == dev_snd_latch);
            if (wr_start && sel.dev == dev_snd_latch) snd_latch <= sel.wdata[7:0];
            if (wr_start && sel.dev == dev_prisel)    prisel    <= sel.wdata[2:0];

            lvbl_l <= lvbl;
            if (wr_start && sel.dev == dev_vint_clr)
                vint <= 1'b0;
            else if (lvbl_l && !lvbl)
                vint <= 1'b1;      // vertical blank start

            sec2_l <= sec2;
            if (wr_start && sel.dev == dev_sec_clr)
                secirq <= 1'b0;
            else if (sec2 && !sec2_l)
                secirq <= 1'b1;    // sub cpu request
        end
    end

    always_comb begin
        if (vint)
            ipl_n = ~3'd6;
        else if (secirq)
            ipl_n = ~3'd5;
        else if (!nexirq_n)
            ipl_n = ~3'd4;
        else
            ipl_n = 3'b111;
    end

endmodule

// File: rtl/dtack_gen.sv
// acknowledge stage, rom/ram ready wait and display blank lock
module dtack_gen import main_pkg::*; #(
    parameter int disp_delay = 2   // 1 to 7
) (
    input  logic   clk,
    input  logic   rst,
    bus_sel_if.ack sel,
    input  logic   rom_ok,
    input  logic   ram_ok,
    input  logic   lvbl,
    input  logic   lhbl,
    output logic   dtack_n
);

    dtack_state_e state;
    logic [2:0]   cnt;        // cycles since blank start
    logic         blank, blank_l, ready;

    assign blank = ~lvbl | ~lhbl;

    always_comb begin
        case (sel.dev)
            dev_rom: ready = rom_ok;
            dev_ram: ready = ram_ok;
            default: ready = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= dt_idle;
            cnt     <= 3'd0;
            blank_l <= 1'b1;   // no false blank edge out of reset
        end else begin
            blank_l <= blank;
            if (!sel.sel_valid) begin
                state <= dt_idle;
            end else begin
                case (state)
                    dt_idle:
                        state <= (sel.dev == dev_disp) ? dt_wait_blank : dt_wait_ready;
                    dt_wait_ready:
                        if (ready) state <= dt_ack;
                    dt_wait_blank:
                        if (blank && !blank_l) begin   // blank just started
                            state <= dt_blank_count;
                            cnt   <= 3'd1;
                        end
                    dt_blank_count:
                        if (cnt >= 3'(disp_delay)) begin
                            if (ram_ok) state <= dt_ack;
                        end else begin
                            cnt <= cnt + 3'd1;
                        end
                    dt_ack:
                        state <= dt_ack;   // held until as_n rises
                    default:
                        state <= dt_idle;
                endcase
            end
        end
    end

    // released together with sel_valid
    assign dtack_n = !((state == dt_ack) && sel.sel_valid);

endmodule

// File: rtl/read_mux.sv
// data stage, read word registered from the selected source
module read_mux import main_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    bus_sel_if.data sel,
    input  word_t   rom_data,
    input  word_t   ram_data,
    input  word_t   pal_dout,
    input  word_t   joy_word,
    input  word_t   sys_word,
    input  word_t   dip_word,
    output word_t   cpu_din
);

    logic  valid_l;
    word_t src;

    always_comb begin
        case (sel.dev)
            dev_rom:            src = rom_data;
            dev_ram, dev_disp:  src = ram_data;   // same sdram port
            dev_pal:            src = pal_dout;
            dev_cab_joy:        src = joy_word;
            dev_cab_sys:        src = sys_word;
            dev_cab_dip:        src = dip_word;
            default:            src = 16'hffff;   // open bus
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_l <= 1'b0;
        else
            valid_l <= sel.sel_valid;
    end

    // load once per cycle, hold until as_n rises
    always_ff @(posedge clk) begin
        if (sel.sel_valid && !valid_l)
            cpu_din <= src;
    end

endmodule

// File: rtl/cab_inputs.sv
// cabinet input formatting, joystick, system and dip switch words
module cab_inputs import main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] joystick1,
    input  logic [8:0] joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       lvbl,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b,
    output word_t      joy_word,
    output word_t      sys_word,
    output word_t      dip_word
);

    logic [8:0] sort1, sort2;

    // board wires the four directions in reverse order
    function automatic logic [8:0] sort_joy(input logic [8:0] joy_in);
        return {joy_in[8:4], joy_in[0], joy_in[1], joy_in[2], joy_in[3]};
    endfunction

    assign sort1 = sort_joy(joystick1);
    assign sort2 = sort_joy(joystick2);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joy_word <= 16'hffff;   // nothing pressed
            sys_word <= 16'hffff;
            dip_word <= 16'hffff;
        end else begin
            joy_word <= {sort2[7:0], sort1[7:0]};
            sys_word <= {8'hff, ~lvbl, service, coin_input, start_button,
                         sort2[8], sort1[8]};
            dip_word <= {dipsw_b, dipsw_a};
        end
    end

endmodule

// File: rtl/addr_decoder.sv
// address decode stage, registered device code, cycle start strobe and chip selects
module addr_decoder import main_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   as_n,
    input  logic   rnw,
    input  logic   uds_n,
    input  logic   lds_n,
    input  waddr_t addr,
    input  word_t  cpu_dout,
    bus_sel_if.src sel,
    output logic   rom_cs,
    output logic   ram_cs,
    output logic   pal_cs
);

    dev_e dev_nxt;

    function automatic logic in_rng(input waddr_t a, input waddr_t base, input waddr_t size);
        return (a >= base) && (a < base + size);
    endfunction

    always_comb begin
        dev_nxt = dev_none;
        if (uds_n && lds_n) begin
            dev_nxt = dev_none;   // no data strobe, nothing to select
        end else if (in_rng(addr, rom_base, rom_size)) begin
            dev_nxt = rnw ? dev_rom : dev_none;
        end else if (in_rng(addr, ram_base, ram_size)) begin
            dev_nxt = dev_ram;
        end else if (in_rng(addr, disp_base, disp_size)) begin
            dev_nxt = dev_disp;
        end else if (in_rng(addr, pal_base, pal_size)) begin
            dev_nxt = dev_pal;
        end else begin
            case (addr)
                cab_joy_addr:   dev_nxt = rnw ? dev_cab_joy : dev_none;
                cab_sys_addr:   dev_nxt = rnw ? dev_cab_sys : dev_none;
                cab_dip_addr:   dev_nxt = rnw ? dev_cab_dip : dev_none;
                wr_snd_addr:    dev_nxt = rnw ? dev_none : dev_snd_latch;
                wr_vint_addr:   dev_nxt = rnw ? dev_none : dev_vint_clr;
                wr_prisel_addr: dev_nxt = rnw ? dev_none : dev_prisel;
                wr_sec_addr:    dev_nxt = rnw ? dev_none : dev_sec_clr;
                default:        dev_nxt = dev_none;   // unmapped, still acked
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel.dev       <= dev_none;
            sel.rnw       <= 1'b1;
            sel.sel_valid <= 1'b0;
            sel.sel_start <= 1'b0;
        end else begin
            sel.sel_valid <= ~as_n;
            sel.sel_start <= ~as_n & ~sel.sel_valid;   // rising edge of sel_valid
            if (!as_n && !sel.sel_valid) begin
                sel.dev <= dev_nxt;
                sel.rnw <= rnw;
            end
        end
    end

    // write data is only consumed on sel_start
    always_ff @(posedge clk) begin
        if (!as_n && !sel.sel_valid)
            sel.wdata <= cpu_dout;
    end

    assign rom_cs = sel.sel_valid && (sel.dev == dev_rom);
    assign ram_cs = sel.sel_valid && (sel.dev == dev_ram || sel.dev == dev_disp);
    assign pal_cs = sel.sel_valid && (sel.dev == dev_pal);

endmodule

// File: rtl/bus_sel_if.sv
// decoded bus cycle passed from the decode stage to data, acknowledge and control
interface bus_sel_if import main_pkg::*; ();

    dev_e  dev;         // device of the open cycle
    logic  rnw;
    word_t wdata;
    logic  sel_valid;   // level, high while the cycle is open
    logic  sel_start;   // first cycle of sel_valid only

    modport src  (output dev, output rnw, output wdata,
                  output sel_valid, output sel_start);

    modport data (input dev, input sel_valid);

    modport ack  (input dev, input sel_valid);

    modport ctrl (input dev, input rnw, input wdata, input sel_start);

endinterface

// File: rtl/main_pkg.sv
// bus word types, device and acknowledge enums, main cpu memory map
package main_pkg;

    typedef logic [15:0] word_t;
    typedef logic [17:0] waddr_t;   // cpu a[18:1]
    typedef logic [2:0]  ipl_t;     // active low level

    // device reached by one bus cycle
    typedef enum logic [3:0] {
        dev_none, dev_rom, dev_ram, dev_disp, dev_pal,
        dev_cab_joy, dev_cab_sys, dev_cab_dip,
        dev_snd_latch, dev_vint_clr, dev_prisel, dev_sec_clr
    } dev_e;

    typedef enum logic [2:0] {
        dt_idle, dt_wait_ready, dt_wait_blank, dt_blank_count, dt_ack
    } dtack_state_e;

    // regions as word addresses (byte address >> 1)
    localparam waddr_t rom_base  = 18'h00000;  // 0x00000-0x5ffff
    localparam waddr_t rom_size  = 18'h30000;
    localparam waddr_t ram_base  = 18'h30000;  // system ram 0x60000-0x6ffff
    localparam waddr_t ram_size  = 18'h08000;
    localparam waddr_t disp_base = 18'h38000;  // display ram 0x70000-0x73fff
    localparam waddr_t disp_size = 18'h02000;
    localparam waddr_t pal_base  = 18'h3a000;  // palette 0x74000-0x747ff
    localparam waddr_t pal_size  = 18'h00400;

    localparam waddr_t cab_joy_addr   = 18'h3c000;  // 0x78000
    localparam waddr_t cab_sys_addr   = 18'h3c001;
    localparam waddr_t cab_dip_addr   = 18'h3c002;
    localparam waddr_t wr_snd_addr    = 18'h3d000;  // 0x7a000
    localparam waddr_t wr_vint_addr   = 18'h3d001;
    localparam waddr_t wr_prisel_addr = 18'h3d002;
    localparam waddr_t wr_sec_addr    = 18'h3d003;

endpackage
